// File: tb/mips_decode_stim.txt
# columns: valid  instruction(hex)  irq  expected op(decimal)  expected unsigned flag
# an idle line (valid 0, irq 0) is stretched by 0 to 3 random idle cycles
1 20221234 0 9 0
1 2464fffe 0 9 1
1 28a60010 0 10 0
1 2ce88000 0 10 1
1 312a00ff 0 11 0
1 356cf0f0 0 12 0
1 39ae5a5a 0 13 0
1 3c0fabcd 0 14 0
1 3c2fabcd 0 0 0
1 83b00004 0 21 0
1 87b00004 0 22 0
1 8bb00004 0 24 0
1 8fb00004 0 23 0
1 93b00004 0 21 1
1 97b00004 0 22 1
1 9bb00004 0 25 0
1 a3b00004 0 26 0
1 a7b00004 0 27 0
1 abb00004 0 29 0
1 afb00004 0 28 0
1 bbb00004 0 30 0
0 00000000 0 0 0
1 04400008 0 1 0
1 04410008 0 2 0
1 04500008 0 3 0
1 04510008 0 4 0
1 04420008 0 0 0
1 1c410010 0 0 0
1 40056000 0 15 0
1 40856000 0 16 0
1 42000018 0 17 0
1 42000002 0 19 0
1 42000008 0 20 0
1 4200003f 0 0 0
1 bc810040 0 31 0
1 bc870040 0 0 0
1 00221821 0 44 1
1 000428c0 1 33 0
1 00c7402b 0 50 1
1 00221801 0 0 0
1 08123456 0 51 0
1 42000020 0 18 0
1 20221234 0 9 0
0 00000000 0 0 0
1 2464fffe 1 9 1
1 0ffffffc 0 52 0

// File: mips_decode.f
+incdir+hw
hw/mips_decode_pkg.sv
hw/id_i.sv
hw/id_r.sv
hw/decode_merge.sv
hw/decode_ctrl.sv
hw/inst_counter.sv
hw/mips_decode_top.sv
tb/tb_mips_decode.sv

// File: Bender.yml
package:
  name: mips_decode

sources:
  - include_dirs:
      - hw
    files:
      - hw/mips_decode_pkg.sv
      - hw/id_i.sv
      - hw/id_r.sv
      - hw/decode_merge.sv
      - hw/decode_ctrl.sv
      - hw/inst_counter.sv
      - hw/mips_decode_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - tb/tb_mips_decode.sv

// File: tb/tb_mips_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_decode_settings.svh"

module tb_mips_decode;

    logic                      clk;
    logic                      arst_n;
    logic                      inst_valid;
    logic [`INST_W-1:0]        inst;
    logic                      irq;
    logic                      dec_valid;
    mips_decode_pkg::decoded_t dec;
    logic                      sleeping;
    logic [`COUNT_W-1:0]       inst_count;

    // stimulus table, one entry per cycle
    logic                      st_valid[$];
    logic [`INST_W-1:0]        st_inst[$];
    logic                      st_irq[$];
    logic [7:0]                st_op[$];
    logic                      st_uns[$];

    mips_decode_pkg::decoded_t exp_q[$];
    logic                      sleep_m;  // model of the run/sleep state
    logic [`COUNT_W-1:0]       seen;
    integer                    seed;
    integer                    limit_cycles = 0;

    mips_decode_top DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .irq        (irq),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .sleeping   (sleeping),
        .inst_count (inst_count)
    );

    always #2 clk = ~clk;

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_dec(input mips_decode_pkg::decoded_t got,
                             input mips_decode_pkg::decoded_t exp);
        if (got !== exp) begin
            $display("MISMATCH %0t: decoded record %h (op %0d), expected %h (op %0d)",
                     $time, got, got.op, exp, exp.op);
            stop_run();
        end
    endtask

    task automatic check_state(input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %0t: sleeping is %b, expected %b", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input logic [`COUNT_W-1:0] got,
                               input logic [`COUNT_W-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %0t: inst_count is %0d, expected %0d", $time, got, exp);
            stop_run();
        end
    endtask

    // fields straight from the instruction word, rd only for special
    function automatic mips_decode_pkg::decoded_t expected_record(
            input logic [`INST_W-1:0] word, input logic [7:0] op, input logic uns);
        mips_decode_pkg::decoded_t r;
        r               = '0;
        r.op            = mips_decode_pkg::op_t'(op);
        r.reg_s         = word[25:21];
        r.reg_t         = word[20:16];
        r.immediate     = word[15:0];
        r.flag_unsigned = uns;
        if (word[31:26] == 6'h00)
            r.reg_d = word[15:11];
        return r;
    endfunction

    task automatic load_stim();
        integer             fd;
        integer             code;
        integer             op;
        integer             gap;
        string              line;
        logic               v;
        logic               q;
        logic               u;
        logic [`INST_W-1:0] w;
        fd = $fopen("tb/mips_decode_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/mips_decode_stim.txt");
            stop_run();
        end
        while ($fgets(line, fd)) begin
            code = 0;
            if (line.getc(0) != "#")
                code = $sscanf(line, "%d %h %d %d %d", v, w, q, op, u);
            if (code == 5) begin
                gap = 0;
                if (!v && !q)
                    gap = $random(seed) & 3;  // idle lines stretch a little
                repeat (gap + 1) begin
                    st_valid.push_back(v);
                    st_inst.push_back(w);
                    st_irq.push_back(q);
                    st_op.push_back(op[7:0]);
                    st_uns.push_back(u);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_cycle(input logic v, input logic [`INST_W-1:0] w, input logic q,
                             input logic [7:0] op, input logic u);
        mips_decode_pkg::decoded_t exp_rec;
        logic                      wait_out;
        @(posedge clk);
        #1;
        inst_valid = v;
        inst       = w;
        irq        = q;
        @(negedge clk);
        wait_out = 1'b0;
        if (dec_valid && exp_q.size() == 0) begin
            $display("ERROR at %0t: dec_valid high with no instruction pending", $time);
            stop_run();
        end
        if (!dec_valid && exp_q.size() != 0) begin
            $display("ERROR at %0t: expected dec_valid did not arrive", $time);
            stop_run();
        end
        if (dec_valid) begin
            exp_rec  = exp_q.pop_front();
            check_dec(dec, exp_rec);
            wait_out = (exp_rec.op == mips_decode_pkg::OP_WAIT);
        end
        check_state(sleeping, sleep_m);
        check_count(inst_count, seen);
        if (dec_valid)
            seen = seen + 1'b1;
        if (v && !sleep_m && !wait_out)
            exp_q.push_back(expected_record(w, op, u));
        if (!sleep_m && wait_out)
            sleep_m = 1'b1;
        else if (sleep_m && q)
            sleep_m = 1'b0;
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        irq        = 1'b0;
        sleep_m    = 1'b0;
        seen       = '0;
        seed       = 20;
        load_stim();
        limit_cycles = st_inst.size() + 50;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        if (dec_valid !== 1'b0) begin
            $display("ERROR at %0t: dec_valid not low after reset", $time);
            stop_run();
        end
        check_dec(dec, '0);
        check_state(sleeping, 1'b0);
        check_count(inst_count, '0);
        for (int i = 0; i < st_inst.size(); i++)
            run_cycle(st_valid[i], st_inst[i], st_irq[i], st_op[i], st_uns[i]);
        repeat (3) run_cycle(1'b0, '0, 1'b0, 8'd0, 1'b0);  // drain
        check_count(inst_count, seen);
        $display("Simulation passed");
        $finish;
    end

    // watchdog
    initial begin
        wait (limit_cycles > 0);
        #(limit_cycles * 4);
        $display("ERROR: timeout, the run did not end within %0d cycles", limit_cycles);
        stop_run();
    end

endmodule

`default_nettype wire

// File: hw/mips_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_decode_settings.svh"

module mips_decode_top (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       inst_valid,
    input  wire [`INST_W-1:0]         inst,
    input  wire                       irq,
    output logic                      dec_valid,
    output mips_decode_pkg::decoded_t dec,
    output logic                      sleeping,
    output logic [`COUNT_W-1:0]       inst_count
);

    mips_decode_pkg::decoded_t dec_i;
    mips_decode_pkg::decoded_t dec_r;
    logic                      accept;

    id_i u_id_i (
        .inst (inst),
        .dec  (dec_i)
    );

    id_r u_id_r (
        .inst (inst),
        .dec  (dec_r)
    );

    decode_merge u_decode_merge (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec_i      (dec_i),
        .dec_r      (dec_r),
        .accept     (accept),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

    decode_ctrl u_decode_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec_op    (dec.op),
        .irq       (irq),
        .accept    (accept),
        .sleeping  (sleeping)
    );

    inst_counter u_inst_counter (
        .clk        (clk),
        .arst_n     (arst_n),
        .dec_valid  (dec_valid),
        .inst_count (inst_count)
    );

endmodule

`default_nettype wire

// File: hw/inst_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_decode_settings.svh"

module inst_counter (
    input  wire                clk,
    input  wire                arst_n,
    input  wire                dec_valid,
    output logic [`COUNT_W-1:0] inst_count
);

    // counts invalid ops as well, wraps at full scale
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inst_count <= '0;
        end else if (dec_valid) begin
            inst_count <= inst_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/decode_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       dec_valid,
    input  wire mips_decode_pkg::op_t dec_op,
    input  wire                       irq,
    output logic                      accept,
    output logic                      sleeping
);

    mips_decode_pkg::ctrl_state_t state;
    mips_decode_pkg::ctrl_state_t state_nxt;
    logic                         wait_out;

    // wait on the output register
    assign wait_out = dec_valid && (dec_op == mips_decode_pkg::OP_WAIT);

    always_comb begin
        state_nxt = state;
        case (state)
            mips_decode_pkg::ST_RUN:   if (wait_out) state_nxt = mips_decode_pkg::ST_SLEEP;
            mips_decode_pkg::ST_SLEEP: if (irq) state_nxt = mips_decode_pkg::ST_RUN;
            default:                   state_nxt = mips_decode_pkg::ST_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= mips_decode_pkg::ST_RUN;
        end else begin
            state <= state_nxt;
        end
    end

    // stop already in the wait cycle, so the next input is dropped
    assign accept   = (state == mips_decode_pkg::ST_RUN) && !wait_out;
    assign sleeping = (state == mips_decode_pkg::ST_SLEEP);

endmodule

`default_nettype wire

// File: hw/decode_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_decode_settings.svh"

module decode_merge (
    input  wire                            clk,
    input  wire                            arst_n,
    input  wire                            inst_valid,
    input  wire [`INST_W-1:0]              inst,
    input  wire mips_decode_pkg::decoded_t dec_i,
    input  wire mips_decode_pkg::decoded_t dec_r,
    input  wire                            accept,
    output logic                           dec_valid,
    output mips_decode_pkg::decoded_t      dec
);

    logic                      sel_r;
    logic                      load;
    mips_decode_pkg::decoded_t dec_sel;

    // special, j and jal go through the r decoder
    assign sel_r = (inst[31:26] == 6'h00) ||
                   (inst[31:26] == 6'h02) ||
                   (inst[31:26] == 6'h03);

    assign dec_sel = sel_r ? dec_r : dec_i;
    assign load    = inst_valid && accept;  // dropped while not accepting

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            dec       <= '0;
        end else begin
            dec_valid <= load;
            if (load) begin
                dec <= dec_sel;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/id_r.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_decode_settings.svh"

module id_r (
    input  wire [`INST_W-1:0]         inst,
    output mips_decode_pkg::decoded_t dec
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];

    always_comb begin
        dec           = '0;
        dec.reg_s     = inst[25:21];
        dec.reg_t     = inst[20:16];
        dec.immediate = inst[15:0];  // shamt/funct, or low jump target

        case (opcode)
            6'h00: begin
                dec.reg_d         = inst[15:11];
                dec.flag_unsigned = (funct == 6'h21) ||  // addu
                                    (funct == 6'h23) ||  // subu
                                    (funct == 6'h2b) ||  // sltu
                                    (funct == 6'h19) ||  // multu
                                    (funct == 6'h1b);    // divu
                case (funct)
                    6'h00:        dec.op = mips_decode_pkg::OP_SLL;
                    6'h02:        dec.op = mips_decode_pkg::OP_SRL;
                    6'h03:        dec.op = mips_decode_pkg::OP_SRA;
                    6'h08:        dec.op = mips_decode_pkg::OP_JR;
                    6'h09:        dec.op = mips_decode_pkg::OP_JALR;
                    6'h10:        dec.op = mips_decode_pkg::OP_MFHI;
                    6'h12:        dec.op = mips_decode_pkg::OP_MFLO;
                    6'h18, 6'h19: dec.op = mips_decode_pkg::OP_MULT;
                    6'h1a, 6'h1b: dec.op = mips_decode_pkg::OP_DIV;
                    6'h20, 6'h21: dec.op = mips_decode_pkg::OP_ADDR;
                    6'h22, 6'h23: dec.op = mips_decode_pkg::OP_SUBR;
                    6'h24:        dec.op = mips_decode_pkg::OP_ANDR;
                    6'h25:        dec.op = mips_decode_pkg::OP_ORR;
                    6'h26:        dec.op = mips_decode_pkg::OP_XORR;
                    6'h27:        dec.op = mips_decode_pkg::OP_NOR;
                    6'h2a, 6'h2b: dec.op = mips_decode_pkg::OP_SLTR;
                    // syscall and break trap here too
                    default:      dec.op = mips_decode_pkg::OP_INVALID;
                endcase
            end
            6'h02:   dec.op = mips_decode_pkg::OP_J;
            6'h03:   dec.op = mips_decode_pkg::OP_JAL;
            default: dec.op = mips_decode_pkg::OP_INVALID;  // not an r-class opcode
        endcase
    end

endmodule

`default_nettype wire

// File: hw/id_i.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_decode_settings.svh"

module id_i (
    input  wire [`INST_W-1:0]         inst,
    output mips_decode_pkg::decoded_t dec
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rs;
    logic [4:0] rt;
    logic       cache_illegal;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];

    // reserved cache operation encodings
    assign cache_illegal = (rt == 5'b11000) || (&rt[2:1]);

    always_comb begin
        dec               = '0;
        dec.reg_s         = rs;
        dec.reg_t         = rt;
        dec.immediate     = inst[15:0];
        dec.flag_unsigned = (opcode == 6'h09) ||  // addiu
                            (opcode == 6'h0b) ||  // sltiu
                            (opcode == 6'h24) ||  // lbu
                            (opcode == 6'h25);    // lhu

        case (opcode)
            6'h01: begin  // regimm, op picked by rt
                case (rt)
                    5'h00:   dec.op = mips_decode_pkg::OP_BLTZ;
                    5'h01:   dec.op = mips_decode_pkg::OP_BGEZ;
                    5'h10:   dec.op = mips_decode_pkg::OP_BLTZAL;
                    5'h11:   dec.op = mips_decode_pkg::OP_BGEZAL;
                    default: dec.op = mips_decode_pkg::OP_INVALID;
                endcase
            end
            6'h04:        dec.op = mips_decode_pkg::OP_BEQ;
            6'h05:        dec.op = mips_decode_pkg::OP_BNE;
            6'h06:        dec.op = (rt == 5'h0) ? mips_decode_pkg::OP_BLEZ
                                                : mips_decode_pkg::OP_INVALID;
            6'h07:        dec.op = (rt == 5'h0) ? mips_decode_pkg::OP_BGTZ
                                                : mips_decode_pkg::OP_INVALID;
            6'h08, 6'h09: dec.op = mips_decode_pkg::OP_ADD;
            6'h0a, 6'h0b: dec.op = mips_decode_pkg::OP_SLT;
            6'h0c:        dec.op = mips_decode_pkg::OP_AND;
            6'h0d:        dec.op = mips_decode_pkg::OP_OR;
            6'h0e:        dec.op = mips_decode_pkg::OP_XOR;
            6'h0f:        dec.op = (rs == 5'h0) ? mips_decode_pkg::OP_LU
                                                : mips_decode_pkg::OP_INVALID;
            6'h10: begin
                // cp0 moves by rs, co functions when rs[4] set
                if (rs == 5'h0) begin
                    dec.op = mips_decode_pkg::OP_MFC0;
                end else if (rs == 5'h4) begin
                    dec.op = mips_decode_pkg::OP_MTC0;
                end else if (rs[4]) begin
                    if (funct == 6'h18)
                        dec.op = mips_decode_pkg::OP_ERET;
                    else if (funct == 6'h20)
                        dec.op = mips_decode_pkg::OP_WAIT;
                    else if (funct == 6'h02 && `WITH_TLB != 0)
                        dec.op = mips_decode_pkg::OP_TLBWI;
                    else if (funct == 6'h08 && `WITH_TLB != 0)
                        dec.op = mips_decode_pkg::OP_TLBP;
                    else
                        dec.op = mips_decode_pkg::OP_INVALID;
                end else begin
                    dec.op = mips_decode_pkg::OP_INVALID;
                end
            end
            6'h20, 6'h24: dec.op = mips_decode_pkg::OP_LB;
            6'h21, 6'h25: dec.op = mips_decode_pkg::OP_LH;
            6'h23:        dec.op = mips_decode_pkg::OP_LW;
            6'h22:        dec.op = mips_decode_pkg::OP_LWL;
            6'h26:        dec.op = mips_decode_pkg::OP_LWR;
            6'h28:        dec.op = mips_decode_pkg::OP_SB;
            6'h29:        dec.op = mips_decode_pkg::OP_SH;
            6'h2b:        dec.op = mips_decode_pkg::OP_SW;
            6'h2a:        dec.op = mips_decode_pkg::OP_SWL;
            6'h2e:        dec.op = mips_decode_pkg::OP_SWR;
            6'h2f:        dec.op = (`WITH_CACHE != 0 && !cache_illegal)
                                   ? mips_decode_pkg::OP_CACHE
                                   : mips_decode_pkg::OP_INVALID;
            6'h33:        dec.op = mips_decode_pkg::OP_PREF;
            default:      dec.op = mips_decode_pkg::OP_INVALID;  // ll/sc not decoded
        endcase
    end

endmodule

`default_nettype wire

// File: hw/mips_decode_pkg.sv
`default_nettype none

package mips_decode_pkg;

    // decoded operations, encodings shared with the stimulus file
    typedef enum logic [7:0] {
        OP_INVALID = 8'd0,
        OP_BLTZ    = 8'd1,
        OP_BGEZ    = 8'd2,
        OP_BLTZAL  = 8'd3,
        OP_BGEZAL  = 8'd4,
        OP_BEQ     = 8'd5,
        OP_BNE     = 8'd6,
        OP_BLEZ    = 8'd7,
        OP_BGTZ    = 8'd8,
        OP_ADD     = 8'd9,
        OP_SLT     = 8'd10,
        OP_AND     = 8'd11,
        OP_OR      = 8'd12,
        OP_XOR     = 8'd13,
        OP_LU      = 8'd14,
        OP_MFC0    = 8'd15,
        OP_MTC0    = 8'd16,
        OP_ERET    = 8'd17,
        OP_WAIT    = 8'd18,
        OP_TLBWI   = 8'd19,
        OP_TLBP    = 8'd20,
        OP_LB      = 8'd21,
        OP_LH      = 8'd22,
        OP_LW      = 8'd23,
        OP_LWL     = 8'd24,
        OP_LWR     = 8'd25,
        OP_SB      = 8'd26,
        OP_SH      = 8'd27,
        OP_SW      = 8'd28,
        OP_SWL     = 8'd29,
        OP_SWR     = 8'd30,
        OP_CACHE   = 8'd31,
        OP_PREF    = 8'd32,
        OP_SLL     = 8'd33,
        OP_SRL     = 8'd34,
        OP_SRA     = 8'd35,
        OP_JR      = 8'd36,
        OP_JALR    = 8'd37,
        OP_SYSCALL = 8'd38,
        OP_BREAK   = 8'd39,
        OP_MFHI    = 8'd40,
        OP_MFLO    = 8'd41,
        OP_MULT    = 8'd42,
        OP_DIV     = 8'd43,
        OP_ADDR    = 8'd44,
        OP_SUBR    = 8'd45,
        OP_ANDR    = 8'd46,
        OP_ORR     = 8'd47,
        OP_XORR    = 8'd48,
        OP_NOR     = 8'd49,
        OP_SLTR    = 8'd50,
        OP_J       = 8'd51,
        OP_JAL     = 8'd52
    } op_t;

    typedef enum logic {
        ST_RUN   = 1'b0,
        ST_SLEEP = 1'b1
    } ctrl_state_t;

    typedef struct packed {
        op_t         op;
        logic [4:0]  reg_s;
        logic [4:0]  reg_t;
        logic [4:0]  reg_d;
        logic [15:0] immediate;
        logic        flag_unsigned;
    } decoded_t;

endpackage

`default_nettype wire

// File: hw/mips_decode_settings.svh
`ifndef MIPS_DECODE_SETTINGS_SVH
`define MIPS_DECODE_SETTINGS_SVH

// instruction word width
`define INST_W 32

// width of the delivered-instruction count
`define COUNT_W 16

// optional opcode groups, 1 enables decoding
`define WITH_TLB 1
`define WITH_CACHE 1

`endif
